// ==== source/keypad_pkg.sv ====
`default_nettype none

package keypad_pkg;

  // Bus widths
  localparam int NIB_W  = 4;          // One row or column nibble
  localparam int KEY_W  = 2 * NIB_W;  // Row nibble over column nibble
  localparam int DATA_W = 8;          // ASCII letter
  localparam int SEG_W  = 7;          // Segments gfedcba

  // Key code {row, col}, both one-hot, zero when nothing pressed
  typedef logic [KEY_W-1:0] key_t;

  typedef enum logic [2:0] {
    IDLE = 3'd0,
    TAP0 = 3'd1,  // First letter of the key
    TAP1 = 3'd2,
    TAP2 = 3'd3,
    TAP3 = 3'd4,  // Only reached on the four-letter keys
    DONE = 3'd5   // Letter frozen, ready high
  } tap_state_t;

  // One-hot nibbles, bit 3 is index 0
  localparam logic [NIB_W-1:0] R0 = 4'b1000;
  localparam logic [NIB_W-1:0] R1 = 4'b0100;
  localparam logic [NIB_W-1:0] R2 = 4'b0010;
  localparam logic [NIB_W-1:0] R3 = 4'b0001;
  localparam logic [NIB_W-1:0] C0 = 4'b1000;
  localparam logic [NIB_W-1:0] C1 = 4'b0100;
  localparam logic [NIB_W-1:0] C2 = 4'b0010;
  localparam logic [NIB_W-1:0] C3 = 4'b0001;

  // Control keys
  localparam key_t KEY_SUBMIT   = {R3, C0};
  localparam key_t KEY_CLEAR    = {R3, C1};
  localparam key_t KEY_GAME_END = {R2, C3};

  // Keys with four letters
  localparam key_t KEY_SEVEN = {R2, C0};  // PQRS
  localparam key_t KEY_NINE  = {R2, C2};  // WXYZ

  // First letter of each letter key
  localparam logic [DATA_W-1:0] BASE_ABC  = 8'h41;
  localparam logic [DATA_W-1:0] BASE_DEF  = 8'h44;
  localparam logic [DATA_W-1:0] BASE_GHI  = 8'h47;
  localparam logic [DATA_W-1:0] BASE_JKL  = 8'h4A;
  localparam logic [DATA_W-1:0] BASE_MNO  = 8'h4D;
  localparam logic [DATA_W-1:0] BASE_PQRS = 8'h50;
  localparam logic [DATA_W-1:0] BASE_TUV  = 8'h54;
  localparam logic [DATA_W-1:0] BASE_WXYZ = 8'h57;

  // Base letter lookup, zero for anything that is not a letter key
  function automatic logic [DATA_W-1:0] letter_base(input key_t key);
    case (key)
      {R0, C1}: letter_base = BASE_ABC;
      {R0, C2}: letter_base = BASE_DEF;
      {R1, C0}: letter_base = BASE_GHI;
      {R1, C1}: letter_base = BASE_JKL;
      {R1, C2}: letter_base = BASE_MNO;
      KEY_SEVEN: letter_base = BASE_PQRS;
      {R2, C1}: letter_base = BASE_TUV;
      KEY_NINE: letter_base = BASE_WXYZ;
      default:  letter_base = '0;  // Control, invalid or not one-hot
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== source/key_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_scanner #(
  parameter int unsigned SYNC_STAGES = 2  // At least 2
) (
  input  logic                         clk,
  input  logic                         nRst,
  input  logic [keypad_pkg::NIB_W-1:0] read_row,
  input  logic [keypad_pkg::NIB_W-1:0] read_col,
  output logic                         strobe,
  output keypad_pkg::key_t             cur_key,
  output logic [keypad_pkg::NIB_W-1:0] scan_col
);
  import keypad_pkg::*;

  logic [SYNC_STAGES-1:0][NIB_W-1:0] row_sync;  // Entry 0 sits at the pins
  logic [NIB_W-1:0]                  row_dly;   // Previous synchronized row
  logic [NIB_W-1:0]                  row_rise;  // Bits that just went high
  logic [NIB_W-1:0]                  col_q;     // Column, one cycle late
  logic [NIB_W-1:0]                  scan_next;

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      row_sync <= '0;
      row_dly  <= '0;
      col_q    <= '0;
      scan_col <= '0;  // No column driven until reset is released
    end else begin
      row_sync <= {row_sync[SYNC_STAGES-2:0], read_row};  // Shift toward edge detect
      row_dly  <= row_sync[SYNC_STAGES-1];
      col_q    <= read_col;
      scan_col <= scan_next;
    end
  end

  // Rising edge on any synchronized row bit
  assign row_rise = row_sync[SYNC_STAGES-1] & ~row_dly;

  // Needs a column too, otherwise the press is not a key
  assign strobe = (|row_rise) & (|col_q);

  // Column walk, frozen while a row is held
  always_comb begin
    if (|read_row) begin
      scan_next = scan_col;
    end else begin
      case (scan_col)
        4'b1000: scan_next = 4'b0100;
        4'b0100: scan_next = 4'b0010;
        4'b0010: scan_next = 4'b0001;
        default: scan_next = 4'b1000;  // Also restarts from zero after reset
      endcase
    end
  end

  // Raw pins, only when both halves are present
  assign cur_key = ((|read_row) && (|read_col)) ? {read_row, read_col} : '0;

endmodule

`default_nettype wire

// ==== source/multitap_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module multitap_fsm (
  input  logic                          clk,
  input  logic                          nRst,
  input  logic                          strobe,
  input  keypad_pkg::key_t              cur_key,
  output keypad_pkg::tap_state_t        tap_state,
  output keypad_pkg::key_t              prev_key,
  output logic [keypad_pkg::DATA_W-1:0] data,
  output logic                          ready,
  output logic                          game_end
);
  import keypad_pkg::*;

  tap_state_t        next_state;
  key_t              next_prev;
  logic [DATA_W-1:0] next_data;
  logic              next_game_end;
  logic [DATA_W-1:0] base;       // Letter base of the current key
  logic              key_valid;
  logic              in_tap;     // One of TAP0..TAP3
  logic [2:0]        tap_idx;    // Offset from the base letter

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      tap_state <= IDLE;
      prev_key  <= '0;
      data      <= '0;
      ready     <= 1'b0;
      game_end  <= 1'b0;
    end else begin
      tap_state <= next_state;
      prev_key  <= next_prev;
      data      <= next_data;
      ready     <= (next_state == DONE);  // Tracks DONE exactly
      game_end  <= next_game_end;         // Single cycle pulse
    end
  end

  assign base = letter_base(cur_key);

  // Letters plus the three control keys
  assign key_valid = (base != '0) ||
                     (cur_key == KEY_SUBMIT) ||
                     (cur_key == KEY_CLEAR) ||
                     (cur_key == KEY_GAME_END);

  assign in_tap = tap_state inside {TAP0, TAP1, TAP2, TAP3};

  always_comb begin
    next_state    = tap_state;  // Hold by default
    next_data     = data;
    next_prev     = prev_key;
    next_game_end = 1'b0;
    tap_idx       = '0;

    if (strobe && key_valid) begin
      next_prev = cur_key;

      if ((cur_key == KEY_CLEAR) || (cur_key == KEY_GAME_END)) begin
        next_state    = IDLE;
        next_data     = '0;
        next_game_end = (cur_key == KEY_GAME_END);
      end else if (cur_key == KEY_SUBMIT) begin
        if (in_tap) begin
          next_state = DONE;  // Freeze the letter
        end else if (tap_state == DONE) begin
          next_state = IDLE;  // Second submit drops it
          next_data  = '0;
        end
        // Idle submit does nothing
      end else begin
        if (in_tap && (cur_key == prev_key)) begin
          case (tap_state)
            TAP0: next_state = TAP1;
            TAP1: next_state = TAP2;
            TAP2: next_state = ((cur_key == KEY_SEVEN) || (cur_key == KEY_NINE)) ? TAP3 : TAP0;
            default: next_state = TAP0;  // TAP3 wraps
          endcase
        end else begin
          next_state = TAP0;  // New key, or first key after idle/done
        end
        tap_idx   = 3'(next_state - TAP0);
        next_data = base + {{(DATA_W-3){1'b0}}, tap_idx};
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/display_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_driver (
  input  logic                         clk,
  input  logic                         nRst,
  input  logic                         strobe,
  input  logic [keypad_pkg::NIB_W-1:0] read_row,
  input  logic [keypad_pkg::NIB_W-1:0] read_col,
  input  keypad_pkg::key_t             prev_key,
  input  keypad_pkg::tap_state_t       tap_state,
  output logic [keypad_pkg::SEG_W-1:0] ss7,
  output logic [keypad_pkg::SEG_W-1:0] ss6,
  output logic [keypad_pkg::SEG_W-1:0] ss4,
  output logic [keypad_pkg::SEG_W-1:0] ss3,
  output logic [keypad_pkg::SEG_W-1:0] ss0
);
  import keypad_pkg::*;

  logic [NIB_W-1:0] sel_row;  // Last selected position
  logic [NIB_W-1:0] sel_col;

  // One-hot position to digit 0..3
  function automatic logic [SEG_W-1:0] pos_digit(input logic [NIB_W-1:0] pos);
    case (pos)
      4'b1000: pos_digit = 7'b0111111;  // 0
      4'b0100: pos_digit = 7'b0000110;  // 1
      4'b0010: pos_digit = 7'b1011011;  // 2
      4'b0001: pos_digit = 7'b1001111;  // 3
      4'b0000: pos_digit = 7'b1000000;  // Dash, nothing yet
      default: pos_digit = '0;          // Blank on a multi-key press
    endcase
  endfunction

  // Hex digit, gfedcba active high
  function automatic logic [SEG_W-1:0] hex_digit(input logic [NIB_W-1:0] val);
    case (val)
      4'h0: hex_digit = 7'b0111111;
      4'h1: hex_digit = 7'b0000110;
      4'h2: hex_digit = 7'b1011011;
      4'h3: hex_digit = 7'b1001111;
      4'h4: hex_digit = 7'b1100110;
      4'h5: hex_digit = 7'b1101101;
      4'h6: hex_digit = 7'b1111101;
      4'h7: hex_digit = 7'b0000111;
      4'h8: hex_digit = 7'b1111111;
      4'h9: hex_digit = 7'b1100111;
      4'hA: hex_digit = 7'b1110111;
      4'hB: hex_digit = 7'b1111100;
      4'hC: hex_digit = 7'b0111001;
      4'hD: hex_digit = 7'b1011110;
      4'hE: hex_digit = 7'b1111001;
      default: hex_digit = 7'b1110001;  // F
    endcase
  endfunction

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      sel_row <= '0;
      sel_col <= '0;
    end else if (strobe && (|read_col)) begin
      sel_row <= read_row;
      sel_col <= read_col;
    end
  end

  assign ss7 = pos_digit(sel_row);
  assign ss6 = pos_digit(sel_col);
  assign ss4 = hex_digit(prev_key[KEY_W-1:NIB_W]);  // Row nibble
  assign ss3 = hex_digit(prev_key[NIB_W-1:0]);      // Column nibble
  assign ss0 = hex_digit(NIB_W'(tap_state));

endmodule

`default_nettype wire

// ==== source/keypad_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypad_top #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                          clk,
  input  logic                          nRst,
  input  logic [keypad_pkg::NIB_W-1:0]  read_row,
  input  logic [keypad_pkg::NIB_W-1:0]  read_col,
  output logic [keypad_pkg::NIB_W-1:0]  scan_col,
  output logic [keypad_pkg::DATA_W-1:0] data,
  output logic                          ready,
  output logic                          game_end,
  output logic [keypad_pkg::SEG_W-1:0]  ss7,
  output logic [keypad_pkg::SEG_W-1:0]  ss6,
  output logic [keypad_pkg::SEG_W-1:0]  ss4,
  output logic [keypad_pkg::SEG_W-1:0]  ss3,
  output logic [keypad_pkg::SEG_W-1:0]  ss0
);
  import keypad_pkg::*;

  logic       strobe;     // One pulse per press
  key_t       cur_key;    // Live key from the pins
  key_t       prev_key;   // Last valid key
  tap_state_t tap_state;

  key_scanner #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_scanner (
    .clk      (clk),
    .nRst     (nRst),
    .read_row (read_row),
    .read_col (read_col),
    .strobe   (strobe),
    .cur_key  (cur_key),
    .scan_col (scan_col)
  );

  multitap_fsm u_fsm (
    .clk       (clk),
    .nRst      (nRst),
    .strobe    (strobe),
    .cur_key   (cur_key),
    .tap_state (tap_state),
    .prev_key  (prev_key),
    .data      (data),
    .ready     (ready),
    .game_end  (game_end)
  );

  // Position digits read the raw pins on the strobe
  display_driver u_display (
    .clk       (clk),
    .nRst      (nRst),
    .strobe    (strobe),
    .read_row  (read_row),
    .read_col  (read_col),
    .prev_key  (prev_key),
    .tap_state (tap_state),
    .ss7       (ss7),
    .ss6       (ss6),
    .ss4       (ss4),
    .ss3       (ss3),
    .ss0       (ss0)
  );

endmodule

`default_nettype wire

// ==== sim/keypad_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypad_props (
  input logic                   clk,
  input logic                   nRst,
  input logic                   strobe,
  input logic [3:0]             scan_col,
  input logic                   ready,
  input keypad_pkg::tap_state_t tap_state
);
  import keypad_pkg::*;

  // One pulse per press
  a_strobe_single: assert property (@(posedge clk) disable iff (!nRst) strobe |=> !strobe)
    else $error("strobe high for two cycles");

  a_scan_onehot: assert property (@(posedge clk) disable iff (!nRst) $onehot0(scan_col))
    else $error("scan_col not one-hot or zero");

  // Ready only rises on a submit taken in a tap state
  a_ready_rise: assert property (@(posedge clk) disable iff (!nRst)
    $rose(ready) |-> ($past(strobe) && ($past(tap_state) inside {TAP0, TAP1, TAP2, TAP3})))
    else $error("ready rose without a strobe from a tap state");

endmodule

bind keypad_top keypad_props u_props (.*);

`default_nettype wire

// ==== sim/tb_keypad_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_keypad_top;

  localparam int MAX_LINES      = 64;  // Room in the golden table
  localparam int RST_CYCLES     = 16;
  localparam int PRESS_MAX      = 13;  // Longest hold plus release
  localparam int RELEASE_CYCLES = 6;   // Idle cycles after each press
  localparam int SLACK          = 50;

  logic       clk;
  logic       nRst;
  logic [3:0] read_row;
  logic [3:0] read_col;
  logic [3:0] scan_col;
  logic [7:0] data;
  logic       ready;
  logic       game_end;
  logic [6:0] ss7;
  logic [6:0] ss6;
  logic [6:0] ss4;
  logic [6:0] ss3;
  logic [6:0] ss0;

  logic [27:0] golden [MAX_LINES];  // row, col, data, ready, state, game_end count
  logic [31:0] lfsr;
  int          num_lines;
  int          cycle_limit = 1000;
  int          cycles = 0;
  int          ge_count;

  keypad_top #(
    .SYNC_STAGES (2)
  ) dut (
    .clk      (clk),
    .nRst     (nRst),
    .read_row (read_row),
    .read_col (read_col),
    .scan_col (scan_col),
    .data     (data),
    .ready    (ready),
    .game_end (game_end),
    .ss7      (ss7),
    .ss6      (ss6),
    .ss4      (ss4),
    .ss3      (ss3),
    .ss0      (ss0)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // Run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: simulation ran past %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $fatal(1, "Run stopped on timeout");
    end
  end

  // Counts game_end pulses
  always @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      ge_count <= 0;
    end else if (game_end) begin
      ge_count <= ge_count + 1;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Active high gfedcba, tap states 0..5 and one-hot nibbles
  function automatic logic [6:0] seg_of(input logic [3:0] val);
    case (val)
      4'h0: return 7'b0111111;
      4'h1: return 7'b0000110;
      4'h2: return 7'b1011011;
      4'h3: return 7'b1001111;
      4'h4: return 7'b1100110;
      4'h5: return 7'b1101101;
      4'h8: return 7'b1111111;
      default: return 7'b0000000;
    endcase
  endfunction

  // One-hot nibble to index, bit 3 is 0
  function automatic logic [3:0] pos_index(input logic [3:0] pos);
    case (pos)
      4'b1000: return 4'd0;
      4'b0100: return 4'd1;
      4'b0010: return 4'd2;
      default: return 4'd3;
    endcase
  endfunction

  // Letter keys and the three control keys of the key map
  function automatic logic key_known(input logic [7:0] key);
    case (key)
      8'h84, 8'h82, 8'h48, 8'h44, 8'h42, 8'h28, 8'h24, 8'h22: return 1'b1;  // Letters
      8'h18, 8'h14, 8'h21: return 1'b1;  // Submit, clear, game end
      default: return 1'b0;
    endcase
  endfunction

  // Column walk over n idle cycles, zero starts at column 0
  function automatic logic [3:0] walk_col(input logic [3:0] s, input int n);
    logic [3:0] c;
    c = s;
    for (int i = 0; i < n; i++) begin
      c = (c == 4'b0000) ? 4'b1000 : {c[0], c[3:1]};
    end
    return c;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Hold 4..7 cycles, then release; starts and ends on a falling edge
  task automatic press_key(input logic [3:0] row, input logic [3:0] col,
                           input logic [3:0] held_col);
    logic [1:0] extra;
    lfsr     = lfsr_step(lfsr);
    extra[0] = lfsr[0];
    lfsr     = lfsr_step(lfsr);
    extra[1] = lfsr[0];
    read_row = row;
    read_col = col;
    repeat (4 + int'(extra)) @(negedge clk);
    check("scan_col while held", 32'(scan_col), 32'(held_col));  // Frozen by the row
    read_row = '0;
    read_col = '0;
    repeat (RELEASE_CYCLES) @(negedge clk);
  endtask

  initial begin
    logic [27:0] line;
    logic [7:0]  exp_prev;  // Last valid key
    logic [3:0]  exp_scan;
    read_row = '0;
    read_col = '0;
    nRst     = 1'b0;
    lfsr     = 32'h982030fa;
    exp_prev = '0;
    exp_scan = '0;  // Zero out of reset
    for (int i = 0; i < MAX_LINES; i++) begin
      golden[i] = '1;  // Marks unused entries
    end
    $readmemh("sim/keypad_golden.hex", golden);
    num_lines = 0;
    while ((num_lines < MAX_LINES) && (golden[num_lines] != '1)) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("Golden file sim/keypad_golden.hex is missing or empty");
      $display("TEST FAILED");
      $fatal(1, "No stimulus");
    end
    cycle_limit = RST_CYCLES + num_lines * PRESS_MAX + SLACK;

    repeat (RST_CYCLES) @(negedge clk);
    nRst = 1'b1;

    for (int i = 0; i < num_lines; i++) begin
      line = golden[i];
      press_key(line[27:24], line[23:20], exp_scan);
      if (key_known(line[27:20])) begin
        exp_prev = line[27:20];  // Invalid codes keep the old key
      end
      exp_scan = walk_col(exp_scan, RELEASE_CYCLES);  // Walks again once released
      check("data", 32'(data), 32'(line[19:12]));
      check("ready", 32'(ready), 32'(line[8]));
      check("ss0", 32'(ss0), 32'(seg_of(line[7:4])));  // Tap state digit
      check("game_end count", 32'(ge_count), 32'(line[3:0]));
      check("ss7", 32'(ss7), 32'(seg_of(pos_index(line[27:24]))));
      check("ss6", 32'(ss6), 32'(seg_of(pos_index(line[23:20]))));
      check("ss4", 32'(ss4), 32'(seg_of(exp_prev[7:4])));  // Previous key row
      check("ss3", 32'(ss3), 32'(seg_of(exp_prev[3:0])));
      check("scan_col", 32'(scan_col), 32'(exp_scan));
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/keypad_golden.hex ====
// Columns: row(1) col(1) data(2) ready(1) tap_state(1) game_end_count(1)
// All hex, one-hot row and col with bit 3 as index 0, one press per line
444A010
444B020
444C030
444A010
2257010
2258020
2259030
225A040
2257010
1857150
1800000
1800000
8800000
8244010
1144010
1244010
8245020
2850010
2851020
2852030
2853040
1400000
8441010
2100001
2454011
2455021
2456031
2454011
424D011
2100002

// ==== keypad_top.f ====
source/keypad_pkg.sv
source/key_scanner.sv
source/multitap_fsm.sv
source/display_driver.sv
source/keypad_top.sv
sim/keypad_props.sv
sim/tb_keypad_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_keypad_top
FILELIST  ?= keypad_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS   := $(shell grep -v '^+' $(FILELIST))
GOLDEN := sim/keypad_golden.hex
BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(GOLDEN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
